// File: common/mbus_pkg.sv
package mbus_pkg;

    localparam int WORD_W = 32;
    localparam int CTRL_W = 2;

    typedef logic [WORD_W-1:0] mbus_word_t;   // address or data word
    typedef logic [CTRL_W-1:0] mbus_ctrl_t;

    // fields the master holds stable while req is up
    typedef struct packed {
        mbus_word_t addr;
        mbus_word_t data;
        logic       broadcast;
        logic       pend;         // more data words follow
        mbus_ctrl_t control;
    } mbus_rx_t;

endpackage

// File: common/ice_pkg.sv
package ice_pkg;

    localparam int BYTE_W = 8;
    localparam int EID_W = 8;
    localparam int BUF_DEPTH = 64;
    localparam int BUF_AW = $clog2(BUF_DEPTH);
    localparam int LEN_POS = 2;
    localparam int HDR_LEN = 3;       // code, event id, length

    typedef logic [BYTE_W-1:0] ice_byte_t;
    typedef logic [EID_W-1:0]  event_id_t;   // wraps
    typedef logic [BUF_AW-1:0] buf_addr_t;

    localparam ice_byte_t FRAME_CODE = 8'h62;

    typedef enum logic [4:0] {
        st_idle,
        st_code,
        st_eid,
        st_len,
        st_addr0,
        st_addr1,
        st_addr2,
        st_addr3,
        st_data0,
        st_data1,
        st_data2,
        st_data3,
        st_pend,
        st_pend_ack,
        st_pend_wait,
        st_ctrl,
        st_end_ack
    } rx_state_e;

endpackage

// File: mbus_rx_driver/mbus_rx_driver.sv
`timescale 1ns/1ps

module mbus_rx_driver (
    input  logic                clk,
    input  logic                reset,
    input  mbus_pkg::mbus_rx_t  rx,
    input  logic                rx_req,
    input  logic                rx_fail,
    output logic                rx_ack,
    output logic                buf_request,
    input  logic                buf_grant,
    output ice_pkg::ice_byte_t  buf_data,
    output logic                buf_valid,
    input  ice_pkg::event_id_t  event_id,
    output logic                event_inc
);

    ice_pkg::rx_state_e state;
    ice_pkg::rx_state_e next_state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ice_pkg::st_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state  = state;
        buf_request = 1'b1;   // held through the whole frame
        buf_data    = '0;
        buf_valid   = 1'b1;
        event_inc   = 1'b0;
        rx_ack      = 1'b0;

        case (state)
            ice_pkg::st_idle: begin
                buf_request = 1'b0;
                buf_valid   = 1'b0;
                if (rx_fail) begin
                    next_state = ice_pkg::st_end_ack;   // ack a fail, no frame
                end else if (rx_req) begin
                    next_state = ice_pkg::st_code;
                end
            end
            ice_pkg::st_code: begin
                buf_data  = ice_pkg::FRAME_CODE;
                buf_valid = buf_grant;   // stall here while the buffer is busy
                if (buf_grant) begin
                    next_state = ice_pkg::st_eid;
                end
            end
            ice_pkg::st_eid: begin
                buf_data   = event_id;
                event_inc  = 1'b1;
                next_state = ice_pkg::st_len;
            end
            ice_pkg::st_len: begin
                buf_data   = '0;   // patched by the buffer at close
                next_state = ice_pkg::st_addr0;
            end
            ice_pkg::st_addr0: begin
                buf_data   = rx.addr[31:24];
                next_state = ice_pkg::st_addr1;
            end
            ice_pkg::st_addr1: begin
                buf_data   = rx.addr[23:16];
                next_state = ice_pkg::st_addr2;
            end
            ice_pkg::st_addr2: begin
                buf_data   = rx.addr[15:8];
                next_state = ice_pkg::st_addr3;
            end
            ice_pkg::st_addr3: begin
                buf_data   = rx.addr[7:0];
                next_state = ice_pkg::st_data0;
            end
            ice_pkg::st_data0: begin
                buf_data   = rx.data[31:24];
                next_state = ice_pkg::st_data1;
            end
            ice_pkg::st_data1: begin
                buf_data   = rx.data[23:16];
                next_state = ice_pkg::st_data2;
            end
            ice_pkg::st_data2: begin
                buf_data   = rx.data[15:8];
                next_state = ice_pkg::st_data3;
            end
            ice_pkg::st_data3: begin
                buf_data   = rx.data[7:0];
                next_state = ice_pkg::st_pend;
            end
            ice_pkg::st_pend: begin
                buf_valid  = 1'b0;
                next_state = rx.pend ? ice_pkg::st_pend_ack : ice_pkg::st_ctrl;
            end
            ice_pkg::st_pend_ack: begin
                buf_valid = 1'b0;
                rx_ack    = 1'b1;
                if (!rx_req) begin
                    next_state = ice_pkg::st_pend_wait;
                end
            end
            ice_pkg::st_pend_wait: begin
                buf_valid = 1'b0;   // keep the buffer until the next word
                if (rx_req) begin
                    next_state = ice_pkg::st_data0;
                end
            end
            ice_pkg::st_ctrl: begin
                buf_data   = {5'b00000, rx.broadcast, rx.control};
                next_state = ice_pkg::st_end_ack;
            end
            ice_pkg::st_end_ack: begin
                buf_request = 1'b0;   // closes the frame
                buf_valid   = 1'b0;
                rx_ack      = 1'b1;
                // release only once both req and fail are down
                if (!rx_req && !rx_fail) begin
                    next_state = ice_pkg::st_idle;
                end
            end
            default: begin
                buf_request = 1'b0;
                buf_valid   = 1'b0;
                next_state  = ice_pkg::st_idle;
            end
        endcase
    end

    // a byte only goes out under a standing, granted request
    assert property (@(posedge clk) disable iff (reset)
        buf_valid |-> buf_request && buf_grant);

    // ack answers a req or a fail, never mid-write
    assert property (@(posedge clk) disable iff (reset)
        $rose(rx_ack) |-> !buf_valid && (rx_req || rx_fail));

endmodule

// File: msg_buffer/msg_buffer.sv
`timescale 1ns/1ps

module msg_buffer (
    input  logic                clk,
    input  logic                reset,
    input  logic                buf_request,
    output logic                buf_grant,
    input  ice_pkg::ice_byte_t  buf_data,
    input  logic                buf_valid,
    output ice_pkg::event_id_t  event_id,
    input  logic                event_inc,
    output logic                frame_req,
    output ice_pkg::buf_addr_t  frame_len,
    input  logic                frame_ack,
    input  ice_pkg::buf_addr_t  rd_addr,
    output ice_pkg::ice_byte_t  rd_data
);

    localparam int CNT_W = ice_pkg::BUF_AW + 1;

    ice_pkg::ice_byte_t mem [ice_pkg::BUF_DEPTH];

    logic [CNT_W-1:0]   wr_cnt;   // one wider so a full buffer is visible
    logic               req_q;
    logic               held;     // closed frame waiting for the host
    logic               wr_en;
    logic               close;
    logic [CNT_W-1:0]   body_len;

    assign buf_grant = buf_request & ~held;
    assign wr_en     = buf_valid & ~held;
    assign close     = req_q & ~buf_request;
    assign body_len  = wr_cnt - CNT_W'(ice_pkg::HDR_LEN);   // bytes after the length slot
    assign frame_len = ice_pkg::buf_addr_t'(body_len);
    assign rd_data   = mem[rd_addr];

    always_ff @(posedge clk) begin
        if (close) begin
            mem[ice_pkg::buf_addr_t'(ice_pkg::LEN_POS)] <= ice_pkg::ice_byte_t'(body_len);
        end else if (wr_en) begin
            mem[wr_cnt[ice_pkg::BUF_AW-1:0]] <= buf_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            event_id <= '0;
        end else if (event_inc) begin
            event_id <= event_id + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_cnt    <= '0;
            req_q     <= 1'b0;
            held      <= 1'b0;
            frame_req <= 1'b0;
        end else begin
            req_q <= buf_request;
            if (wr_en) begin
                wr_cnt <= wr_cnt + 1'b1;
            end
            if (close) begin
                held <= 1'b1;
            end
            if (frame_req && frame_ack) begin
                frame_req <= 1'b0;
                held      <= 1'b0;
                wr_cnt    <= '0;
            end else if (held && !frame_req) begin
                frame_req <= 1'b1;   // length is in place by now
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset) wr_cnt <= CNT_W'(ice_pkg::BUF_DEPTH));

    // driver must not write while the host still owns the frame
    assert property (@(posedge clk) disable iff (reset) held |-> !buf_valid);

endmodule

// File: hdl/host_tx.sv
`timescale 1ns/1ps

module host_tx (
    input  logic                clk,
    input  logic                reset,
    input  logic                frame_req,
    input  ice_pkg::buf_addr_t  frame_len,
    output logic                frame_ack,
    output ice_pkg::buf_addr_t  rd_addr,
    input  ice_pkg::ice_byte_t  rd_data,
    output ice_pkg::ice_byte_t  host_data,
    output logic                host_req,
    input  logic                host_ack
);

    typedef enum logic [2:0] {
        tx_idle,
        tx_load,
        tx_req,
        tx_ack_low,
        tx_done
    } tx_state_e;

    tx_state_e          state;
    ice_pkg::buf_addr_t last_addr;

    assign last_addr = frame_len + ice_pkg::buf_addr_t'(ice_pkg::HDR_LEN - 1);

    always_ff @(posedge clk) begin
        if (state == tx_load) begin
            host_data <= rd_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= tx_idle;
            rd_addr   <= '0;
            host_req  <= 1'b0;
            frame_ack <= 1'b0;
        end else begin
            case (state)
                tx_idle: begin
                    if (frame_req) begin
                        state <= tx_load;
                    end
                end
                tx_load: begin
                    host_req <= 1'b1;
                    state    <= tx_req;
                end
                tx_req: begin
                    if (host_ack) begin
                        host_req <= 1'b0;
                        state    <= tx_ack_low;
                    end
                end
                tx_ack_low: begin
                    if (!host_ack) begin   // byte done, host back to idle
                        if (rd_addr == last_addr) begin
                            frame_ack <= 1'b1;
                            state     <= tx_done;
                        end else begin
                            rd_addr <= rd_addr + 1'b1;
                            state   <= tx_load;
                        end
                    end
                end
                tx_done: begin
                    if (!frame_req) begin
                        frame_ack <= 1'b0;
                        rd_addr   <= '0;
                        state     <= tx_idle;
                    end
                end
                default: state <= tx_idle;
            endcase
        end
    end

    // the buffer keeps the frame until every byte is through
    assert property (@(posedge clk) disable iff (reset)
        host_req && $past(host_req) |-> $stable(host_data) && frame_req);

endmodule

// File: hdl/ice_rx_top.sv
`timescale 1ns/1ps

module ice_rx_top (
    input  logic                clk,
    input  logic                reset,
    input  mbus_pkg::mbus_rx_t  rx,
    input  logic                rx_req,
    input  logic                rx_fail,
    output logic                rx_ack,
    output ice_pkg::ice_byte_t  host_data,
    output logic                host_req,
    input  logic                host_ack
);

    logic               buf_request;
    logic               buf_grant;
    ice_pkg::ice_byte_t buf_data;
    logic               buf_valid;
    ice_pkg::event_id_t event_id;
    logic               event_inc;

    logic               frame_req;
    logic               frame_ack;
    ice_pkg::buf_addr_t frame_len;
    ice_pkg::buf_addr_t rd_addr;
    ice_pkg::ice_byte_t rd_data;

    mbus_rx_driver u_driver (
        .clk         (clk),
        .reset       (reset),
        .rx          (rx),
        .rx_req      (rx_req),
        .rx_fail     (rx_fail),
        .rx_ack      (rx_ack),
        .buf_request (buf_request),
        .buf_grant   (buf_grant),
        .buf_data    (buf_data),
        .buf_valid   (buf_valid),
        .event_id    (event_id),
        .event_inc   (event_inc)
    );

    msg_buffer u_buffer (
        .clk         (clk),
        .reset       (reset),
        .buf_request (buf_request),
        .buf_grant   (buf_grant),
        .buf_data    (buf_data),
        .buf_valid   (buf_valid),
        .event_id    (event_id),
        .event_inc   (event_inc),
        .frame_req   (frame_req),
        .frame_len   (frame_len),
        .frame_ack   (frame_ack),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data)
    );

    host_tx u_host_tx (
        .clk         (clk),
        .reset       (reset),
        .frame_req   (frame_req),
        .frame_len   (frame_len),
        .frame_ack   (frame_ack),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .host_data   (host_data),
        .host_req    (host_req),
        .host_ack    (host_ack)
    );

endmodule

// File: test/tb_ice_rx.sv
`timescale 1ns/1ps

module tb_ice_rx;

    localparam int TIMEOUT = 2000;   // cycles per wait
    localparam int FRAMES = 260;     // enough to wrap the event id

    logic               clk = 1'b0;
    logic               reset = 1'b1;
    mbus_pkg::mbus_rx_t rx = '0;
    logic               rx_req = 1'b0;
    logic               rx_fail = 1'b0;
    logic               rx_ack;
    ice_pkg::ice_byte_t host_data;
    logic               host_req;
    logic               host_ack = 1'b0;

    ice_pkg::ice_byte_t exp_q [$];   // expected host bytes of all frames in order
    ice_pkg::event_id_t exp_eid = '0;
    logic [15:0]        master_lfsr = 16'd37435;
    logic [15:0]        host_lfsr = 16'd37435;
    int                 ack_rises = 0;
    logic               ack_seen = 1'b0;
    int                 frames_sent = 0;
    string              test_name = "reset";

    ice_rx_top UUT (
        .clk       (clk),
        .reset     (reset),
        .rx        (rx),
        .rx_req    (rx_req),
        .rx_fail   (rx_fail),
        .rx_ack    (rx_ack),
        .host_data (host_data),
        .host_req  (host_req),
        .host_ack  (host_ack)
    );

    always #5 clk = ~clk;

    // count rx_ack rising edges
    always @(negedge clk) begin
        if (rx_ack === 1'b1 && !ack_seen) begin
            ack_rises <= ack_rises + 1;
        end
        ack_seen <= (rx_ack === 1'b1);
    end

    task automatic fail_msg(input string what);
        $display("[ERROR] %s: %s", test_name, what);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic fail_value(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        $display("[ERROR] %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
        $display("Test failed");
        $fatal(1);
    endtask

    // host may only start a byte once it has dropped ack
    assert property (@(posedge clk) disable iff (reset) $rose(host_req) |-> !host_ack)
        else fail_msg("host_req rose while host_ack was still high");

    // galois form, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    task automatic draw_bits(inout logic [15:0] state, input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            state = lfsr_step(state);
            value = {value[30:0], state[0]};
        end
    endtask

    task automatic check_quiet();
        assert (host_req === 1'b0) else fail_value("host_req", 32'd0, 32'(host_req));
        assert (rx_ack === 1'b0) else fail_value("rx_ack", 32'd0, 32'(rx_ack));
    endtask

    task automatic wait_rx_ack(input logic level);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (rx_ack !== level) begin
            cycles++;
            if (cycles > TIMEOUT) begin
                fail_msg("timed out waiting for rx_ack");
            end
            @(negedge clk);
        end
    endtask

    task automatic wait_host_req(input logic level);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (host_req !== level) begin
            cycles++;
            if (cycles > TIMEOUT) begin
                fail_msg("timed out waiting for host_req");
            end
            @(negedge clk);
        end
    endtask

    task automatic drain_frames();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (exp_q.size() != 0 || host_req !== 1'b0 || host_ack !== 1'b0) begin
            cycles++;
            if (cycles > TIMEOUT) begin
                fail_msg("expected frames never reached the host");
            end
            @(negedge clk);
        end
    endtask

    task automatic push_word(input mbus_pkg::mbus_word_t word);
        exp_q.push_back(word[31:24]);   // msb first
        exp_q.push_back(word[23:16]);
        exp_q.push_back(word[15:8]);
        exp_q.push_back(word[7:0]);
    endtask

    task automatic send_msg(input int words);
        mbus_pkg::mbus_word_t addr;
        mbus_pkg::mbus_word_t data [3];
        mbus_pkg::mbus_ctrl_t ctrl;
        mbus_pkg::mbus_rx_t   word;
        logic [31:0]          bits;
        logic                 bcast;
        int                   frame_bytes;
        int                   rises_before;
        draw_bits(master_lfsr, 32, bits);
        addr = bits;
        for (int w = 0; w < words; w++) begin
            draw_bits(master_lfsr, 32, bits);
            data[w] = bits;
        end
        draw_bits(master_lfsr, 1, bits);
        bcast = bits[0];
        draw_bits(master_lfsr, 2, bits);
        ctrl = bits[1:0];
        // code, id, length, address, data, control
        frame_bytes = 4 * words + 8;
        exp_q.push_back(8'h62);
        exp_q.push_back(exp_eid);
        exp_q.push_back(8'(4 * words + 5));
        push_word(addr);
        for (int w = 0; w < words; w++) begin
            push_word(data[w]);
        end
        exp_q.push_back({5'b00000, bcast, ctrl});
        exp_eid = exp_eid + 1'b1;
        frames_sent++;
        rises_before = ack_rises;
        for (int w = 0; w < words; w++) begin
            word.addr = addr;
            word.data = data[w];
            word.broadcast = bcast;
            word.pend = (w < words - 1);
            word.control = ctrl;
            @(posedge clk);
            rx <= word;
            rx_req <= 1'b1;
            wait_rx_ack(1'b1);
            // earlier frames must be fully with the host before any ack
            assert (exp_q.size() == frame_bytes)
                else fail_value("bytes queued at ack", 32'(frame_bytes), 32'(exp_q.size()));
            @(posedge clk);
            rx_req <= 1'b0;
            wait_rx_ack(1'b0);
        end
        assert (ack_rises - rises_before == words)
            else fail_value("ack count", 32'(words), 32'(ack_rises - rises_before));
    endtask

    task automatic send_fail();
        int rises_before;
        rises_before = ack_rises;
        @(posedge clk);
        rx_fail <= 1'b1;
        wait_rx_ack(1'b1);
        @(posedge clk);
        rx_fail <= 1'b0;
        wait_rx_ack(1'b0);
        assert (ack_rises - rises_before == 1)
            else fail_value("fail ack count", 32'd1, 32'(ack_rises - rises_before));
    endtask

    initial begin : host_model
        logic [31:0]        delay;
        ice_pkg::ice_byte_t expected;
        forever begin
            wait_host_req(1'b1);
            assert (exp_q.size() > 0) else fail_msg("host byte arrived with no frame expected");
            expected = exp_q.pop_front();
            assert (host_data == expected)
                else fail_value("host byte", 32'(expected), 32'(host_data));
            draw_bits(host_lfsr, 3, delay);   // slow host
            repeat (delay) @(posedge clk);
            @(posedge clk);
            host_ack <= 1'b1;
            wait_host_req(1'b0);
            @(posedge clk);
            host_ack <= 1'b0;
        end
    end

    initial begin : stimulus
        logic [31:0] pick;
        repeat (2) begin
            @(negedge clk);
            check_quiet();
        end
        @(posedge clk);
        reset <= 1'b0;
        repeat (2) begin
            @(negedge clk);
            check_quiet();
        end

        test_name = "single word";
        repeat (3) send_msg(1);
        test_name = "pending";
        send_msg(2);
        send_msg(3);
        test_name = "fail in idle";
        send_fail();
        send_msg(1);

        // messages back to back, the slow host holds each frame
        test_name = "back to back";
        while (frames_sent < FRAMES) begin
            if (frames_sent % 32 == 7) begin
                send_fail();
            end
            draw_bits(master_lfsr, 2, pick);
            send_msg(int'(pick % 3) + 1);
        end
        drain_frames();
        $display("Test passed");
        $finish;
    end

endmodule

// File: ice_rx.f
common/mbus_pkg.sv
common/ice_pkg.sv
mbus_rx_driver/mbus_rx_driver.sv
msg_buffer/msg_buffer.sv
hdl/host_tx.sv
hdl/ice_rx_top.sv
test/tb_ice_rx.sv

// File: Makefile
VERILATOR  ?= verilator
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
TOP        := tb_ice_rx
FILELIST   := ice_rx.f
BUILD_DIR  := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
